// ==== Bender.yml ====
package:
  name: reg_read

sources:
  - include_dirs:
      - include
    files:
      - hw/core_pkg.sv
      - hw/reg_file.sv
      - hw/csr_file.sv
      - hw/reg_read.sv
      - hw/reg_read_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - test/tb_reg_read.sv

// ==== hw/core_pkg.sv ====
`include "core_cfg.svh"

package core_pkg;

    typedef enum logic [2:0] {
        op_alu,
        op_load,
        op_store,
        op_branch,
        op_csr
    } uop_op_e;

    // csrs held by csr_file, standard machine-mode addresses
    typedef enum logic [`CORE_CSR_AW-1:0] {
        csr_mtvec    = 12'h305,
        csr_mscratch = 12'h340,
        csr_mepc     = 12'h341,
        csr_mcause   = 12'h342
    } csr_idx_e;

    typedef struct packed {
        logic                    valid;
        uop_op_e                 op;
        logic [`CORE_XLEN-1:0]   pc;
        logic [`CORE_XLEN-1:0]   imm;
        logic [`CORE_TAG_W-1:0]  tag;
        logic [`CORE_REG_AW-1:0] rs1;
        logic                    rs1_en;
        logic [`CORE_REG_AW-1:0] rs2;
        logic                    rs2_en;
        logic [`CORE_REG_AW-1:0] rd;
        logic                    rd_alloc;
        logic [`CORE_CSR_AW-1:0] csr_addr;
        logic                    csr_rd_en;
        logic                    csr_alloc;
    } dec_uop_t;

    // source addresses replaced by operand data
    typedef struct packed {
        logic                    valid;
        uop_op_e                 op;
        logic [`CORE_XLEN-1:0]   pc;
        logic [`CORE_XLEN-1:0]   imm;
        logic [`CORE_TAG_W-1:0]  tag;
        logic                    rs1_en;
        logic [`CORE_XLEN-1:0]   rs1_data;
        logic                    rs2_en;
        logic [`CORE_XLEN-1:0]   rs2_data;
        logic [`CORE_REG_AW-1:0] rd;
        logic                    rd_alloc;
        logic [`CORE_CSR_AW-1:0] csr_addr;
        logic                    csr_rd_en;
        logic                    csr_alloc;
        logic [`CORE_XLEN-1:0]   csr_data;
    } exe_uop_t;

endpackage

// ==== hw/csr_file.sv ====
`timescale 1ns/100ps

`include "core_cfg.svh"

module csr_file import core_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    input  logic [`CORE_CSR_AW-1:0] rd_addr_i,
    output logic [`CORE_XLEN-1:0]   rd_data_o,
    output logic                    rd_ready_o,

    input  logic                    alloc_i,     // allocates the csr on rd_addr_i
    input  logic [`CORE_TAG_W-1:0]  alloc_tag_i,

    input  logic                    wb_valid_i,
    input  logic [`CORE_CSR_AW-1:0] wb_addr_i,
    input  logic [`CORE_TAG_W-1:0]  wb_tag_i,
    input  logic [`CORE_XLEN-1:0]   wb_data_i
);

    localparam int NCSR = 4;

    logic [`CORE_XLEN-1:0]  data_q [NCSR];
    logic [`CORE_TAG_W-1:0] tag_q  [NCSR];
    logic [NCSR-1:0]        busy_q;

    logic [2:0] rd_slot;  // {hit, index}
    logic [2:0] wb_slot;
    logic       alloc_ok;
    logic       wb_ok;
    logic       dup_tag;

    // address decode onto the four storage slots
    function automatic logic [2:0] csr_slot(input logic [`CORE_CSR_AW-1:0] addr);
        case (addr)
            csr_mscratch: return 3'b100;
            csr_mtvec:    return 3'b101;
            csr_mepc:     return 3'b110;
            csr_mcause:   return 3'b111;
            default:      return 3'b000;
        endcase
    endfunction

    assign rd_slot = csr_slot(rd_addr_i);
    assign wb_slot = csr_slot(wb_addr_i);

    assign alloc_ok = alloc_i && rd_slot[2];
    assign wb_ok    = wb_valid_i && wb_slot[2]
                   && busy_q[wb_slot[1:0]]
                   && (tag_q[wb_slot[1:0]] == wb_tag_i)
                   && !(alloc_ok && (rd_slot[1:0] == wb_slot[1:0]));

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            busy_q <= '0;
            for (int i = 0; i < NCSR; i++) begin
                data_q[i] <= '0;
            end
        end else begin
            if (wb_ok) begin
                data_q[wb_slot[1:0]] <= wb_data_i;
                busy_q[wb_slot[1:0]] <= 1'b0;
            end
            if (alloc_ok) begin
                busy_q[rd_slot[1:0]] <= 1'b1;
                tag_q[rd_slot[1:0]]  <= alloc_tag_i;
            end
        end
    end

    // unknown addresses read zero and never stall
    assign rd_data_o  = rd_slot[2] ? data_q[rd_slot[1:0]] : '0;
    assign rd_ready_o = !rd_slot[2] || !busy_q[rd_slot[1:0]];

    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < NCSR; i++) begin
            for (int j = i + 1; j < NCSR; j++) begin
                if (busy_q[i] && busy_q[j] && (tag_q[i] == tag_q[j])) dup_tag = 1'b1;
            end
        end
    end

    // tags are unique among in-flight micro-ops
    a_unique_tag: assert property (@(posedge clk_i) disable iff (!rstn_i) !dup_tag);

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/100ps

`include "core_cfg.svh"

module reg_file (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    input  logic [`CORE_REG_AW-1:0] rd_addr1_i,
    output logic [`CORE_XLEN-1:0]   rd_data1_o,
    output logic                    rd_ready1_o,
    input  logic [`CORE_REG_AW-1:0] rd_addr2_i,
    output logic [`CORE_XLEN-1:0]   rd_data2_o,
    output logic                    rd_ready2_o,

    input  logic                    alloc_i,
    input  logic [`CORE_REG_AW-1:0] alloc_addr_i,
    input  logic [`CORE_TAG_W-1:0]  alloc_tag_i,

    input  logic                    wb_valid_i,
    input  logic [`CORE_REG_AW-1:0] wb_addr_i,
    input  logic [`CORE_TAG_W-1:0]  wb_tag_i,
    input  logic [`CORE_XLEN-1:0]   wb_data_i
);

    logic [`CORE_XLEN-1:0]  data_q [`CORE_NREG];
    logic [`CORE_TAG_W-1:0] tag_q  [`CORE_NREG];
    logic [`CORE_NREG-1:0]  busy_q;

    logic alloc_ok;
    logic wb_ok;

    // x0 is never tracked
    assign alloc_ok = alloc_i && (alloc_addr_i != '0);

    // stale or untracked writebacks are dropped; allocation wins a collision
    assign wb_ok = wb_valid_i
                && busy_q[wb_addr_i]
                && (tag_q[wb_addr_i] == wb_tag_i)
                && !(alloc_ok && (alloc_addr_i == wb_addr_i));

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            busy_q <= '0;
            for (int i = 0; i < `CORE_NREG; i++) begin
                data_q[i] <= '0;
            end
        end else begin
            if (wb_ok) begin
                data_q[wb_addr_i] <= wb_data_i;
                busy_q[wb_addr_i] <= 1'b0;
            end
            if (alloc_ok) begin
                busy_q[alloc_addr_i] <= 1'b1;
                tag_q[alloc_addr_i]  <= alloc_tag_i;
            end
        end
    end

    // both read ports see x0 as zero and always ready
    assign rd_data1_o  = (rd_addr1_i == '0) ? '0 : data_q[rd_addr1_i];
    assign rd_ready1_o = (rd_addr1_i == '0) || !busy_q[rd_addr1_i];
    assign rd_data2_o  = (rd_addr2_i == '0) ? '0 : data_q[rd_addr2_i];
    assign rd_ready2_o = (rd_addr2_i == '0) || !busy_q[rd_addr2_i];

    // the stage must filter rd == x0 before requesting an allocation
    a_no_x0_alloc: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(alloc_i && (alloc_addr_i == '0))
    );

endmodule

// ==== hw/reg_read.sv ====
`timescale 1ns/100ps

`include "core_cfg.svh"

module reg_read import core_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    input  dec_uop_t                dec_uop_i,
    output logic                    stall_o,

    output exe_uop_t                exe_uop_o,
    input  logic                    exe_stall_i,
    input  logic                    flush_i,

    input  logic                    wb_valid_i,
    input  logic [`CORE_REG_AW-1:0] wb_addr_i,
    input  logic [`CORE_TAG_W-1:0]  wb_tag_i,
    input  logic [`CORE_XLEN-1:0]   wb_data_i,

    output logic [`CORE_CSR_AW-1:0] csr_addr_o,
    output logic                    csr_alloc_o,
    output logic [`CORE_TAG_W-1:0]  csr_tag_o,
    input  logic [`CORE_XLEN-1:0]   csr_data_i,
    input  logic                    csr_ready_i
);

    logic [`CORE_XLEN-1:0] rs1_data;
    logic [`CORE_XLEN-1:0] rs2_data;
    logic                  rs1_ready;
    logic                  rs2_ready;
    logic                  hazard;
    logic                  accept;
    logic                  rd_alloc;

    exe_uop_t exe_d;
    exe_uop_t exe_q;

    reg_file i_reg_file (
        .clk_i        ( clk_i         ),
        .rstn_i       ( rstn_i        ),
        .rd_addr1_i   ( dec_uop_i.rs1 ),
        .rd_data1_o   ( rs1_data      ),
        .rd_ready1_o  ( rs1_ready     ),
        .rd_addr2_i   ( dec_uop_i.rs2 ),
        .rd_data2_o   ( rs2_data      ),
        .rd_ready2_o  ( rs2_ready     ),
        .alloc_i      ( rd_alloc      ),
        .alloc_addr_i ( dec_uop_i.rd  ),
        .alloc_tag_i  ( dec_uop_i.tag ),
        .wb_valid_i   ( wb_valid_i    ),
        .wb_addr_i    ( wb_addr_i     ),
        .wb_tag_i     ( wb_tag_i      ),
        .wb_data_i    ( wb_data_i     )
    );

    assign hazard = dec_uop_i.valid
                 && ((dec_uop_i.rs1_en    && !rs1_ready)
                  || (dec_uop_i.rs2_en    && !rs2_ready)
                  || (dec_uop_i.csr_rd_en && !csr_ready_i));

    assign stall_o = hazard || exe_stall_i;
    assign accept  = dec_uop_i.valid && !hazard && !exe_stall_i && !flush_i;

    // destinations are marked busy only for accepted micro-ops
    assign rd_alloc    = accept && dec_uop_i.rd_alloc && (dec_uop_i.rd != '0);
    assign csr_alloc_o = accept && dec_uop_i.csr_alloc;
    assign csr_addr_o  = dec_uop_i.csr_addr;
    assign csr_tag_o   = dec_uop_i.tag;

    always_comb begin
        exe_d.valid     = accept;  // a hazard leaves a bubble
        exe_d.op        = dec_uop_i.op;
        exe_d.pc        = dec_uop_i.pc;
        exe_d.imm       = dec_uop_i.imm;
        exe_d.tag       = dec_uop_i.tag;
        exe_d.rs1_en    = dec_uop_i.rs1_en;
        exe_d.rs1_data  = dec_uop_i.rs1_en ? rs1_data : '0;
        exe_d.rs2_en    = dec_uop_i.rs2_en;
        exe_d.rs2_data  = dec_uop_i.rs2_en ? rs2_data : '0;
        exe_d.rd        = dec_uop_i.rd;
        exe_d.rd_alloc  = dec_uop_i.rd_alloc;
        exe_d.csr_addr  = dec_uop_i.csr_addr;
        exe_d.csr_rd_en = dec_uop_i.csr_rd_en;
        exe_d.csr_alloc = dec_uop_i.csr_alloc;
        exe_d.csr_data  = dec_uop_i.csr_rd_en ? csr_data_i : '0;
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            exe_q <= '0;
        end else if (flush_i) begin
            exe_q.valid <= 1'b0;  // flush beats hold
        end else if (!exe_stall_i) begin
            exe_q <= exe_d;
        end
    end

    assign exe_uop_o = exe_q;

    a_flush_clears: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        flush_i |=> !exe_uop_o.valid
    );

    a_hold_on_stall: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (exe_stall_i && !flush_i) |=> $stable(exe_uop_o)
    );

endmodule

// ==== hw/reg_read_top.sv ====
`timescale 1ns/100ps

`include "core_cfg.svh"

module reg_read_top import core_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    input  dec_uop_t                dec_uop_i,
    output logic                    stall_o,
    output exe_uop_t                exe_uop_o,
    input  logic                    exe_stall_i,
    input  logic                    flush_i,

    input  logic                    wb_valid_i,
    input  logic [`CORE_REG_AW-1:0] wb_addr_i,
    input  logic [`CORE_TAG_W-1:0]  wb_tag_i,
    input  logic [`CORE_XLEN-1:0]   wb_data_i,

    input  logic                    csr_wb_valid_i,
    input  logic [`CORE_CSR_AW-1:0] csr_wb_addr_i,
    input  logic [`CORE_TAG_W-1:0]  csr_wb_tag_i,
    input  logic [`CORE_XLEN-1:0]   csr_wb_data_i
);

    logic [`CORE_CSR_AW-1:0] csr_addr;
    logic                    csr_alloc;
    logic [`CORE_TAG_W-1:0]  csr_tag;
    logic [`CORE_XLEN-1:0]   csr_data;
    logic                    csr_ready;

    reg_read i_reg_read (
        .clk_i       ( clk_i       ),
        .rstn_i      ( rstn_i      ),
        .dec_uop_i   ( dec_uop_i   ),
        .stall_o     ( stall_o     ),
        .exe_uop_o   ( exe_uop_o   ),
        .exe_stall_i ( exe_stall_i ),
        .flush_i     ( flush_i     ),
        .wb_valid_i  ( wb_valid_i  ),
        .wb_addr_i   ( wb_addr_i   ),
        .wb_tag_i    ( wb_tag_i    ),
        .wb_data_i   ( wb_data_i   ),
        .csr_addr_o  ( csr_addr    ),
        .csr_alloc_o ( csr_alloc   ),
        .csr_tag_o   ( csr_tag     ),
        .csr_data_i  ( csr_data    ),
        .csr_ready_i ( csr_ready   )
    );

    csr_file i_csr_file (
        .clk_i       ( clk_i          ),
        .rstn_i      ( rstn_i         ),
        .rd_addr_i   ( csr_addr       ),
        .rd_data_o   ( csr_data       ),
        .rd_ready_o  ( csr_ready      ),
        .alloc_i     ( csr_alloc      ),
        .alloc_tag_i ( csr_tag        ),
        .wb_valid_i  ( csr_wb_valid_i ),
        .wb_addr_i   ( csr_wb_addr_i  ),
        .wb_tag_i    ( csr_wb_tag_i   ),
        .wb_data_i   ( csr_wb_data_i  )
    );

endmodule

// ==== include/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// datapath width
`define CORE_XLEN   32

// integer register file
`define CORE_NREG   32
`define CORE_REG_AW 5

// micro-op tag, also used by the busy scoreboard
`define CORE_TAG_W  4

// csr address space
`define CORE_CSR_AW 12

`endif

// ==== reg_read_top.f ====
+incdir+include
hw/core_pkg.sv
hw/reg_file.sv
hw/csr_file.sv
hw/reg_read.sv
hw/reg_read_top.sv
test/tb_reg_read.sv

// ==== test/tb_reg_read.sv ====
`timescale 1ns/100ps

`include "core_cfg.svh"

module tb_reg_read import core_pkg::*; ();

    localparam int RST_CYCLES = 16;

    typedef struct {
        string                   name;
        dec_uop_t                uop;
        logic                    exe_stall;
        logic                    flush;
        logic                    wb_valid;
        logic [`CORE_REG_AW-1:0] wb_addr;
        logic [`CORE_TAG_W-1:0]  wb_tag;
        logic                    csr_wb_valid;
        csr_idx_e                csr_wb_addr;
        logic [`CORE_TAG_W-1:0]  csr_wb_tag;
        logic                    exp_stall;  // stall_o while the row is driven
    } row_t;

    logic                    clk;
    logic                    rstn;
    dec_uop_t                dec_uop;
    logic                    stall;
    exe_uop_t                exe_uop;
    logic                    exe_stall;
    logic                    flush;
    logic                    wb_valid;
    logic [`CORE_REG_AW-1:0] wb_addr;
    logic [`CORE_TAG_W-1:0]  wb_tag;
    logic [`CORE_XLEN-1:0]   wb_data;
    logic                    csr_wb_valid;
    logic [`CORE_CSR_AW-1:0] csr_wb_addr;
    logic [`CORE_TAG_W-1:0]  csr_wb_tag;
    logic [`CORE_XLEN-1:0]   csr_wb_data;

    row_t        rows[$];
    logic [15:0] lfsr;
    int          errors;
    int          cycles;
    int          limit;

    // reference scoreboard
    logic [`CORE_XLEN-1:0]  m_data [`CORE_NREG];
    logic [`CORE_NREG-1:0]  m_busy;
    logic [`CORE_TAG_W-1:0] m_tag  [`CORE_NREG];
    logic [`CORE_XLEN-1:0]  m_csr_data [4];
    logic [3:0]             m_csr_busy;
    logic [`CORE_TAG_W-1:0] m_csr_tag  [4];

    reg_read_top uut (
        .clk_i          ( clk          ),
        .rstn_i         ( rstn         ),
        .dec_uop_i      ( dec_uop      ),
        .stall_o        ( stall        ),
        .exe_uop_o      ( exe_uop      ),
        .exe_stall_i    ( exe_stall    ),
        .flush_i        ( flush        ),
        .wb_valid_i     ( wb_valid     ),
        .wb_addr_i      ( wb_addr      ),
        .wb_tag_i       ( wb_tag       ),
        .wb_data_i      ( wb_data      ),
        .csr_wb_valid_i ( csr_wb_valid ),
        .csr_wb_addr_i  ( csr_wb_addr  ),
        .csr_wb_tag_i   ( csr_wb_tag   ),
        .csr_wb_data_i  ( csr_wb_data  )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_word(output logic [`CORE_XLEN-1:0] w);
        w = '0;
        for (int i = 0; i < `CORE_XLEN; i++) begin
            w    = {w[`CORE_XLEN-2:0], lfsr[0]};  // one step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic int csr_index(input logic [`CORE_CSR_AW-1:0] addr);
        case (addr)
            csr_mscratch: return 0;
            csr_mtvec:    return 1;
            csr_mepc:     return 2;
            csr_mcause:   return 3;
            default:      return -1;
        endcase
    endfunction

    function automatic logic [`CORE_XLEN-1:0] reg_value(input logic [`CORE_REG_AW-1:0] a);
        return (a == '0) ? '0 : m_data[a];
    endfunction

    function automatic logic [`CORE_XLEN-1:0] csr_value(input logic [`CORE_CSR_AW-1:0] a);
        int idx;
        idx = csr_index(a);
        return (idx < 0) ? '0 : m_csr_data[idx];
    endfunction

    // integer micro-op
    function automatic dec_uop_t mk_uop(input logic [3:0] tag,
                                        input logic s1_en, input logic [4:0] s1,
                                        input logic s2_en, input logic [4:0] s2,
                                        input logic d_alloc, input logic [4:0] d);
        dec_uop_t u;
        u          = '0;
        u.valid    = 1'b1;
        u.op       = op_alu;
        u.pc       = 32'h0000_1000 + 32'(tag) * 4;
        u.imm      = 32'h00A5_0000 | 32'(tag);
        u.tag      = tag;
        u.rs1_en   = s1_en;
        u.rs1      = s1;
        u.rs2_en   = s2_en;
        u.rs2      = s2;
        u.rd_alloc = d_alloc;
        u.rd       = d;
        return u;
    endfunction

    function automatic dec_uop_t mk_csr(input logic [3:0] tag, input logic [11:0] addr,
                                        input logic rd_en, input logic alloc);
        dec_uop_t u;
        u           = mk_uop(tag, 1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 5'd0);
        u.op        = op_csr;
        u.csr_addr  = addr;
        u.csr_rd_en = rd_en;
        u.csr_alloc = alloc;
        return u;
    endfunction

    task automatic add_row(input string name, input dec_uop_t uop, input logic xs,
                           input logic fl, input logic es);
        row_t r;
        r.name         = name;
        r.uop          = uop;
        r.exe_stall    = xs;
        r.flush        = fl;
        r.wb_valid     = 1'b0;
        r.wb_addr      = '0;
        r.wb_tag       = '0;
        r.csr_wb_valid = 1'b0;
        r.csr_wb_addr  = csr_mscratch;
        r.csr_wb_tag   = '0;
        r.exp_stall    = es;
        rows.push_back(r);
    endtask

    task automatic with_wb(input logic [4:0] addr, input logic [3:0] tag);
        rows[rows.size()-1].wb_valid = 1'b1;
        rows[rows.size()-1].wb_addr  = addr;
        rows[rows.size()-1].wb_tag   = tag;
    endtask

    task automatic with_csr_wb(input csr_idx_e addr, input logic [3:0] tag);
        rows[rows.size()-1].csr_wb_valid = 1'b1;
        rows[rows.size()-1].csr_wb_addr  = addr;
        rows[rows.size()-1].csr_wb_tag   = tag;
    endtask

    task automatic build_table();
        dec_uop_t u;
        u = mk_uop(4'd0, 1'b1, 5'd5, 1'b1, 5'd31, 1'b0, 5'd0);
        u.csr_addr  = csr_mscratch;
        u.csr_rd_en = 1'b1;
        add_row("reset_idle", '0, 1'b0, 1'b0, 1'b0);
        add_row("reset_read", u, 1'b0, 1'b0, 1'b0);
        add_row("alloc_x3", mk_uop(4'd1, 1'b0, 5'd0, 1'b0, 5'd0, 1'b1, 5'd3), 1'b0, 1'b0, 1'b0);
        add_row("wb_x3", '0, 1'b0, 1'b0, 1'b0);
        with_wb(5'd3, 4'd1);
        // rd alloc to x0 is dropped by the stage
        add_row("read_x3", mk_uop(4'd2, 1'b1, 5'd3, 1'b1, 5'd0, 1'b1, 5'd0), 1'b0, 1'b0, 1'b0);
        add_row("alloc_x7", mk_uop(4'd3, 1'b0, 5'd0, 1'b0, 5'd0, 1'b1, 5'd7), 1'b0, 1'b0, 1'b0);
        u = mk_uop(4'd4, 1'b1, 5'd7, 1'b0, 5'd0, 1'b1, 5'd8);
        add_row("hazard_x7", u, 1'b0, 1'b0, 1'b1);
        add_row("hazard_wb", u, 1'b0, 1'b0, 1'b1);  // no bypass, still stalled
        with_wb(5'd7, 4'd3);
        add_row("hazard_accept", u, 1'b0, 1'b0, 1'b0);
        u = mk_uop(4'd5, 1'b1, 5'd3, 1'b1, 5'd8, 1'b0, 5'd0);
        add_row("stale_tag", u, 1'b0, 1'b0, 1'b1);
        with_wb(5'd8, 4'd9);
        add_row("stale_not_busy", u, 1'b0, 1'b0, 1'b1);
        with_wb(5'd3, 4'd1);
        add_row("wb_x8", u, 1'b0, 1'b0, 1'b1);
        with_wb(5'd8, 4'd4);
        add_row("read_x8", u, 1'b0, 1'b0, 1'b0);
        add_row("csr_alloc", mk_csr(4'd6, csr_mepc, 1'b0, 1'b1), 1'b0, 1'b0, 1'b0);
        u = mk_csr(4'd7, csr_mepc, 1'b1, 1'b0);
        add_row("csr_hazard", u, 1'b0, 1'b0, 1'b1);
        with_csr_wb(csr_mepc, 4'd2);
        add_row("csr_wb", u, 1'b0, 1'b0, 1'b1);
        with_csr_wb(csr_mepc, 4'd6);
        add_row("csr_read", u, 1'b0, 1'b0, 1'b0);
        add_row("csr_unknown", mk_csr(4'd8, 12'h7C0, 1'b1, 1'b1), 1'b0, 1'b0, 1'b0);
        // reads its own rd, so an allocation under hold would stall the release
        u = mk_uop(4'd9, 1'b1, 5'd3, 1'b1, 5'd9, 1'b1, 5'd9);
        add_row("exe_stall_hold", u, 1'b1, 1'b0, 1'b1);
        add_row("exe_stall_release", u, 1'b0, 1'b0, 1'b0);
        add_row("flush", mk_uop(4'd10, 1'b0, 5'd0, 1'b0, 5'd0, 1'b1, 5'd10), 1'b0, 1'b1, 1'b0);
        add_row("after_flush", mk_uop(4'd11, 1'b1, 5'd10, 1'b1, 5'd0, 1'b0, 5'd0),
                1'b0, 1'b0, 1'b0);
        add_row("wb_x9", '0, 1'b0, 1'b0, 1'b0);
        with_wb(5'd9, 4'd9);
        add_row("read_x9", mk_uop(4'd12, 1'b1, 5'd9, 1'b1, 5'd3, 1'b0, 5'd0), 1'b0, 1'b0, 1'b0);
        add_row("idle_end", '0, 1'b0, 1'b0, 1'b0);
    endtask

    // pass-through fields plus operand data from the scoreboard model
    function automatic exe_uop_t expect_exe(input dec_uop_t u, input logic valid);
        exe_uop_t e;
        e           = '0;
        e.valid     = valid;
        e.op        = u.op;
        e.pc        = u.pc;
        e.imm       = u.imm;
        e.tag       = u.tag;
        e.rs1_en    = u.rs1_en;
        e.rs1_data  = u.rs1_en ? reg_value(u.rs1) : '0;
        e.rs2_en    = u.rs2_en;
        e.rs2_data  = u.rs2_en ? reg_value(u.rs2) : '0;
        e.rd        = u.rd;
        e.rd_alloc  = u.rd_alloc;
        e.csr_addr  = u.csr_addr;
        e.csr_rd_en = u.csr_rd_en;
        e.csr_alloc = u.csr_alloc;
        e.csr_data  = u.csr_rd_en ? csr_value(u.csr_addr) : '0;
        return e;
    endfunction

    // scoreboard state after the rising edge
    task automatic commit_row(input row_t r, input logic accept,
                              input logic [`CORE_XLEN-1:0] wbd,
                              input logic [`CORE_XLEN-1:0] cwbd);
        logic alloc;
        logic calloc;
        int   ci;
        int   ai;
        alloc  = accept && r.uop.rd_alloc && (r.uop.rd != '0);
        ai     = csr_index(r.uop.csr_addr);
        ci     = csr_index(r.csr_wb_addr);
        calloc = accept && r.uop.csr_alloc && (ai >= 0);
        if (r.wb_valid && m_busy[r.wb_addr] && (m_tag[r.wb_addr] == r.wb_tag)
                && !(alloc && (r.uop.rd == r.wb_addr))) begin
            m_data[r.wb_addr] = wbd;
            m_busy[r.wb_addr] = 1'b0;
        end
        if (alloc) begin
            m_busy[r.uop.rd] = 1'b1;
            m_tag[r.uop.rd]  = r.uop.tag;
        end
        if (r.csr_wb_valid && (ci >= 0) && m_csr_busy[ci] && (m_csr_tag[ci] == r.csr_wb_tag)
                && !(calloc && (ai == ci))) begin
            m_csr_data[ci] = cwbd;
            m_csr_busy[ci] = 1'b0;
        end
        if (calloc) begin
            m_csr_busy[ai] = 1'b1;
            m_csr_tag[ai]  = r.uop.tag;
        end
    endtask

    task automatic check_stall(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s stall_o: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // fields of a bubble are not defined, only its valid bit
    task automatic check_uop(input string name, input exe_uop_t exp, input exe_uop_t act);
        if ((act.valid !== exp.valid) || (exp.valid && (act !== exp))) begin
            $display("FAIL %s exe_uop_o: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    initial begin
        row_t                  r;
        exe_uop_t              exp_out;
        logic                  accept;
        logic [`CORE_XLEN-1:0] wbd;
        logic [`CORE_XLEN-1:0] cwbd;
        int                    errs_before;
        int                    pass_cnt;
        int                    fail_cnt;

        rstn         = 1'b0;
        dec_uop      = '0;
        exe_stall    = 1'b0;
        flush        = 1'b0;
        wb_valid     = 1'b0;
        wb_addr      = '0;
        wb_tag       = '0;
        wb_data      = '0;
        csr_wb_valid = 1'b0;
        csr_wb_addr  = '0;
        csr_wb_tag   = '0;
        csr_wb_data  = '0;
        lfsr         = 16'd57;
        errors       = 0;
        cycles       = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        m_busy       = '0;
        m_csr_busy   = '0;
        for (int i = 0; i < `CORE_NREG; i++) begin
            m_data[i] = '0;
            m_tag[i]  = '0;
        end
        for (int i = 0; i < 4; i++) begin
            m_csr_data[i] = '0;
            m_csr_tag[i]  = '0;
        end
        build_table();
        limit   = 2 * rows.size() + RST_CYCLES;
        exp_out = '0;

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        foreach (rows[i]) begin
            r           = rows[i];
            errs_before = errors;
            rand_word(wbd);
            rand_word(cwbd);
            dec_uop      = r.uop;
            exe_stall    = r.exe_stall;
            flush        = r.flush;
            wb_valid     = r.wb_valid;
            wb_addr      = r.wb_addr;
            wb_tag       = r.wb_tag;
            wb_data      = wbd;
            csr_wb_valid = r.csr_wb_valid;
            csr_wb_addr  = r.csr_wb_addr;
            csr_wb_tag   = r.csr_wb_tag;
            csr_wb_data  = cwbd;

            accept = r.uop.valid && !r.exp_stall && !r.flush;
            if (r.flush) begin
                exp_out.valid = 1'b0;  // flush wins over a hold
            end else if (!r.exe_stall) begin
                exp_out = expect_exe(r.uop, accept);
            end
            commit_row(r, accept, wbd, cwbd);

            #5;
            check_stall(r.name, r.exp_stall, stall);
            @(negedge clk);
            check_uop(r.name, exp_out, exe_uop);
            if (errors == errs_before) begin
                pass_cnt++;
                $display("test %s: ok", r.name);
            end else begin
                fail_cnt++;
                $display("test %s: %0d mismatches", r.name, errors - errs_before);
            end
        end

        $display("tests run: %0d, passed: %0d, failed: %0d", rows.size(), pass_cnt, fail_cnt);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
